/* ac97_audio_pkg.sv */
//--------------------
// ac97 audio types
// sample, stereo pair and fifo level
// types, plus the 48 kHz rate constants
//--------------------

package ac97_audio_pkg;

  typedef logic signed [15:0] sample_t;          // one pcm sample

  // stereo pair, right in the upper half
  typedef struct packed {
    sample_t right;                              // bits 31:16
    sample_t left;                               // bits 15:0
  } stereo_t;

  // fifo fill flags, all derived from the count
  typedef struct packed {
    logic full;                                  // count == depth
    logic half_full;                             // count >= depth/2
    logic half_empty;                            // count < depth/2
    logic empty;                                 // count == 0
  } fifo_level_t;

  // selects the flag behind an interrupt
  typedef enum logic [2:0] {
    irq_none,
    irq_empty,
    irq_half_empty,
    irq_half_full,
    irq_full
  } irq_level_e;

  localparam logic [11:0] rate_ctr_max  = 12'd2604; // short run end value
  localparam logic [2:0]  rate_frac_max = 3'd5;     // long run every sixth period

endpackage

/* ac97_bus_pkg.sv */
//--------------------
// ac97 system bus definitions
// request struct, register map, status
// bits and codec shadow constants
//--------------------

package ac97_bus_pkg;

  // one bus request, held for a single cycle
  typedef struct packed {
    logic [19:0] addr;                           // byte offset
    logic [31:0] wdata;
    logic        wen;
    logic        ren;
  } sys_req_t;

  //--------------------
  // register offsets
  localparam logic [19:0] reg_play_fifo   = 20'h00000; // wo, one sample per write
  localparam logic [19:0] reg_rec_fifo    = 20'h00004; // ro, left then right
  localparam logic [19:0] reg_status      = 20'h00008; // ro
  localparam logic [19:0] reg_fifo_reset  = 20'h0000C; // bit0 play, bit1 rec
  localparam logic [19:0] reg_codec_addr  = 20'h00010; // 6:1 word, 7 read
  localparam logic [19:0] reg_codec_rdata = 20'h00014;
  localparam logic [19:0] reg_codec_wdata = 20'h00018;

  //--------------------
  // status bit positions
  localparam int stat_play_full      = 0;
  localparam int stat_play_half_full = 1;
  localparam int stat_rec_full       = 2;
  localparam int stat_rec_empty      = 3;
  localparam int stat_access_done    = 4;
  localparam int stat_codec_ready    = 5;
  localparam int stat_play_underrun  = 6;
  localparam int stat_rec_overrun    = 7;

  //--------------------
  // codec shadow
  localparam logic [5:0]  codec_status_word = 6'h13;    // byte address 0x26
  localparam logic [15:0] codec_ready_mask  = 16'h000f; // four ready bits
  localparam logic [2:0]  startup_cycles    = 3'd4;     // delay after reset

endpackage

/* ac97_rate_gen.sv */
//--------------------
// ac97 sample rate strobes
// exact 48 kHz and 8 kHz single cycle
// strobes from the 125 MHz clock
//--------------------
`timescale 1ns/1ps

module ac97_rate_gen (
  input  logic clk_adc_125mhz,
  input  logic adc_rstn_i,
  output logic tick_48k_o,
  output logic tick_8k_o
);
  import ac97_audio_pkg::*;

  logic [11:0] ctr_q;                            // period counter
  logic [2:0]  frac_q;                           // short runs since last long one

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ctr_q      <= '0;
      frac_q     <= '0;
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
    end else if (ctr_q == rate_ctr_max) begin
      tick_48k_o <= 1'b1;
      if (frac_q == rate_frac_max) begin         // sixth period, one cycle longer
        frac_q    <= '0;
        ctr_q     <= '0;
        tick_8k_o <= 1'b1;                       // frame boundary
      end else begin
        frac_q    <= frac_q + 3'd1;
        ctr_q     <= 12'd1;                      // short run
        tick_8k_o <= 1'b0;
      end
    end else begin
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
      ctr_q      <= ctr_q + 12'd1;
    end
  end

  // 8k frame only ever lands on a 48k tick
  a_8k_on_48k: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    tick_8k_o |-> tick_48k_o);

endmodule

/* ac97_sample_fifo.sv */
//--------------------
// stereo sample fifo
// circular buffer with show-ahead head,
// fill count and level flags
//--------------------
`timescale 1ns/1ps

module ac97_sample_fifo #(
  parameter int fifo_depth = 16                  // power of two, at least 4
) (
  input  logic                        clk_adc_125mhz,
  input  logic                        adc_rstn_i,
  input  logic                        clear_i,
  input  logic                        push_i,
  input  ac97_audio_pkg::stereo_t     din_i,
  input  logic                        pop_i,
  output ac97_audio_pkg::stereo_t     dout_o,
  output ac97_audio_pkg::fifo_level_t level_o
);
  import ac97_audio_pkg::*;

  localparam int          aw      = $clog2(fifo_depth);
  localparam logic [aw:0] depth_c = (aw+1)'(fifo_depth);
  localparam logic [aw:0] half_c  = (aw+1)'(fifo_depth / 2);

  stereo_t       mem [fifo_depth];
  logic [aw-1:0] wr_ptr_q;
  logic [aw-1:0] rd_ptr_q;
  logic [aw:0]   count_q;
  logic          do_push;
  logic          do_pop;

  assign do_push = push_i && !level_o.full;     // push to full is dropped
  assign do_pop  = pop_i && !level_o.empty;     // pop from empty is ignored

  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push) mem[wr_ptr_q] <= din_i;
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + aw'(1);
      if (do_pop)  rd_ptr_q <= rd_ptr_q + aw'(1);
      if (do_push && !do_pop)      count_q <= count_q + (aw+1)'(1);
      else if (do_pop && !do_push) count_q <= count_q - (aw+1)'(1);
    end
  end

  assign dout_o = mem[rd_ptr_q];                 // show-ahead head word

  // flags follow the count
  assign level_o.empty      = (count_q == '0);
  assign level_o.half_empty = (count_q < half_c);
  assign level_o.half_full  = (count_q >= half_c);
  assign level_o.full       = (count_q == depth_c);

  a_count_range: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    count_q <= depth_c);
  a_empty_full: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    !(level_o.empty && level_o.full));

endmodule

/* ac97_stream_irq.sv */
//--------------------
// ac97 stream interrupts
// per direction fifo level interrupt,
// sticky play underrun and rec overrun
//--------------------
`timescale 1ns/1ps

module ac97_stream_irq #(
  parameter ac97_audio_pkg::irq_level_e play_irq_level = ac97_audio_pkg::irq_half_empty,
  parameter ac97_audio_pkg::irq_level_e rec_irq_level  = ac97_audio_pkg::irq_half_full
) (
  input  logic                        clk_adc_125mhz,
  input  logic                        adc_rstn_i,
  input  logic                        tick_48k_i,
  input  ac97_audio_pkg::fifo_level_t play_level_i,
  input  ac97_audio_pkg::fifo_level_t rec_level_i,
  input  logic                        play_clear_i,
  input  logic                        rec_clear_i,
  output logic                        irq_play_o,
  output logic                        irq_rec_o,
  output logic                        play_underrun_o,
  output logic                        rec_overrun_o
);
  import ac97_audio_pkg::*;

  // flag named by the interrupt level
  function automatic logic pick_flag(irq_level_e sel, fifo_level_t lvl);
    case (sel)
      irq_empty:      return lvl.empty;
      irq_half_empty: return lvl.half_empty;
      irq_half_full:  return lvl.half_full;
      irq_full:       return lvl.full;
      default:        return 1'b0;             // irq_none
    endcase
  endfunction

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      irq_play_o      <= 1'b0;
      irq_rec_o       <= 1'b0;
      play_underrun_o <= 1'b0;
      rec_overrun_o   <= 1'b0;
    end else begin
      irq_play_o <= pick_flag(play_irq_level, play_level_i); // one cycle lag
      irq_rec_o  <= pick_flag(rec_irq_level, rec_level_i);
      if (play_clear_i)
        play_underrun_o <= 1'b0;
      else if (tick_48k_i && play_level_i.empty)
        play_underrun_o <= 1'b1;                 // nothing to play out
      if (rec_clear_i)
        rec_overrun_o <= 1'b0;
      else if (tick_48k_i && rec_level_i.full)
        rec_overrun_o <= 1'b1;                   // capture lost
    end
  end

endmodule

/* ac97_codec_regs.sv */
//--------------------
// ac97 codec register shadow
// 64 x 16 ram, status word always ready,
// access finished flag
//--------------------
`timescale 1ns/1ps

module ac97_codec_regs (
  input  logic                                        clk_adc_125mhz,
  input  logic                                        adc_rstn_i,
  input  logic [5:0]                                  word_addr_i,
  input  logic [$bits(ac97_audio_pkg::sample_t)-1:0]  wdata_i,
  input  logic                                        store_i,
  input  logic                                        recall_i,
  output logic [15:0]                                 rdata_o,
  output logic                                        access_done_o
);
  import ac97_bus_pkg::*;

  logic [15:0] mem [64];                         // codec register shadow
  logic [15:0] mem_q;                            // registered read
  logic [1:0]  recall_d_q;                       // recall delay line
  logic        done_q;

  always_ff @(posedge clk_adc_125mhz) begin
    if (store_i) mem[word_addr_i] <= wdata_i;
    mem_q <= mem[word_addr_i];
    if (recall_d_q[1]) begin
      if (word_addr_i == codec_status_word)
        rdata_o <= mem_q | codec_ready_mask;     // codec always reports ready
      else
        rdata_o <= mem_q;
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      recall_d_q <= '0;
      done_q     <= 1'b0;
    end else begin
      recall_d_q <= {recall_d_q[0], recall_i};
      if (store_i || recall_d_q[1])
        done_q <= 1'b1;                          // write done or read data valid
      else if (recall_i)
        done_q <= 1'b0;
    end
  end

  // low from the first cycle of a new access
  assign access_done_o = done_q && !store_i && !recall_i;

  a_one_access: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    !(store_i && recall_i));

endmodule

/* ac97_bus_regs.sv */
//--------------------
// ac97 system bus registers
// decode, stereo pair assembly, record
// half word readout, start-up delay and
// status word
//--------------------
`timescale 1ns/1ps

module ac97_bus_regs (
  input  logic                        clk_adc_125mhz,
  input  logic                        adc_rstn_i,
  input  ac97_bus_pkg::sys_req_t      sys_req_i,
  output logic [31:0]                 sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        play_push_o,
  output ac97_audio_pkg::stereo_t     play_pair_o,
  output logic                        play_clear_o,
  input  ac97_audio_pkg::stereo_t     rec_head_i,
  output logic                        rec_pop_o,
  output logic                        rec_clear_o,
  input  ac97_audio_pkg::fifo_level_t play_level_i,
  input  ac97_audio_pkg::fifo_level_t rec_level_i,
  input  logic                        play_underrun_i,
  input  logic                        rec_overrun_i,
  output logic [5:0]                  codec_addr_o,
  output logic [15:0]                 codec_wdata_o,
  output logic                        codec_store_o,
  output logic                        codec_recall_o,
  input  logic [15:0]                 codec_rdata_i,
  input  logic                        codec_access_done_i
);
  import ac97_bus_pkg::*;

  logic [2:0]  startup_cnt_q;                    // cycles left in start-up
  logic        startup;
  logic        codec_ready_q;
  logic        play_right_q;                     // next play write is right
  logic        rec_right_q;                      // next rec read is right
  logic [31:0] status;
  logic [31:0] rdata_mux;

  //--------------------
  // start-up delay
  assign startup = (startup_cnt_q != 3'd0);

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      startup_cnt_q <= startup_cycles;
      codec_ready_q <= 1'b0;
    end else begin
      if (startup) startup_cnt_q <= startup_cnt_q - 3'd1;
      codec_ready_q <= !startup;
    end
  end

  //--------------------
  // read side
  always_comb begin
    status                     = '0;
    status[stat_play_full]     = play_level_i.full;
    status[stat_play_half_full] = play_level_i.half_full;
    status[stat_rec_full]      = rec_level_i.full;
    status[stat_rec_empty]     = rec_level_i.empty;
    status[stat_access_done]   = codec_access_done_i;
    status[stat_codec_ready]   = codec_ready_q;
    status[stat_play_underrun] = play_underrun_i;
    status[stat_rec_overrun]   = rec_overrun_i;
  end

  always_comb begin
    case (sys_req_i.addr)
      reg_rec_fifo:    rdata_mux = rec_right_q ? {16'h0, rec_head_i.right}
                                               : {16'h0, rec_head_i.left};
      reg_status:      rdata_mux = status;
      reg_codec_rdata: rdata_mux = {16'h0, codec_rdata_i};
      default:         rdata_mux = '0;         // unmapped reads zero
    endcase
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_req_i.wen || sys_req_i.ren;
      sys_rdata_o <= sys_req_i.ren ? rdata_mux : '0;
    end
  end

  //--------------------
  // write side strobes
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      play_push_o    <= 1'b0;
      play_clear_o   <= 1'b0;
      rec_pop_o      <= 1'b0;
      rec_clear_o    <= 1'b0;
      codec_store_o  <= 1'b0;
      codec_recall_o <= 1'b0;
      codec_addr_o   <= '0;
      play_right_q   <= 1'b0;
      rec_right_q    <= 1'b0;
    end else begin
      play_push_o    <= 1'b0;                    // strobes by default
      rec_pop_o      <= 1'b0;
      codec_store_o  <= 1'b0;
      codec_recall_o <= 1'b0;
      play_clear_o   <= startup;                 // fifos held clear in start-up
      rec_clear_o    <= startup;
      if (startup) begin
        play_right_q <= 1'b0;
        rec_right_q  <= 1'b0;
      end else begin
        if (sys_req_i.wen) begin
          case (sys_req_i.addr)
            reg_play_fifo: begin
              play_push_o  <= play_right_q;      // pair complete after right
              play_right_q <= !play_right_q;
            end
            reg_fifo_reset: begin
              if (sys_req_i.wdata[0]) begin
                play_clear_o <= 1'b1;
                play_right_q <= 1'b0;            // back to left
              end
              if (sys_req_i.wdata[1]) begin
                rec_clear_o <= 1'b1;
                rec_right_q <= 1'b0;
              end
            end
            reg_codec_addr: begin
              codec_addr_o   <= sys_req_i.wdata[6:1];
              codec_recall_o <= sys_req_i.wdata[7];  // bit 7 set reads
              codec_store_o  <= !sys_req_i.wdata[7];
            end
            default: ;
          endcase
        end
        if (sys_req_i.ren && sys_req_i.addr == reg_rec_fifo) begin
          rec_pop_o   <= rec_right_q;            // pop after right half
          rec_right_q <= !rec_right_q;
        end
      end
    end
  end

  // pair and codec write data
  always_ff @(posedge clk_adc_125mhz) begin
    if (sys_req_i.wen && sys_req_i.addr == reg_play_fifo) begin
      if (play_right_q) play_pair_o.right <= sys_req_i.wdata[15:0];
      else              play_pair_o.left  <= sys_req_i.wdata[15:0];
    end
    if (sys_req_i.wen && sys_req_i.addr == reg_codec_wdata)
      codec_wdata_o <= sys_req_i.wdata[15:0];
  end

endmodule

/* ac97_top.sv */
//--------------------
// ac97 audio stream top
// rate strobes, play and record fifos,
// interrupts, codec shadow and bus block
//--------------------
`timescale 1ns/1ps

module ac97_top #(
  parameter int                         fifo_depth     = 16,
  parameter ac97_audio_pkg::irq_level_e play_irq_level = ac97_audio_pkg::irq_half_empty,
  parameter ac97_audio_pkg::irq_level_e rec_irq_level  = ac97_audio_pkg::irq_half_full
) (
  input  logic                    clk_adc_125mhz,
  input  logic                    adc_rstn_i,
  input  ac97_bus_pkg::sys_req_t  sys_req_i,
  output logic [31:0]             sys_rdata_o,
  output logic                    sys_ack_o,
  input  ac97_audio_pkg::stereo_t line_in_i,
  output ac97_audio_pkg::stereo_t line_out_o,
  output logic                    tick_48k_o,
  output logic                    tick_8k_o,
  output logic                    irq_play_o,
  output logic                    irq_rec_o
);
  import ac97_audio_pkg::*;

  stereo_t     play_pair, play_head, rec_head;
  fifo_level_t play_level, rec_level;
  logic        play_push, play_clear, rec_pop, rec_clear;
  logic        play_underrun, rec_overrun;
  logic [5:0]  codec_addr;
  logic [15:0] codec_wdata, codec_rdata;
  logic        codec_store, codec_recall, codec_done;

  ac97_rate_gen rate_gen_i (.clk_adc_125mhz, .adc_rstn_i, .tick_48k_o, .tick_8k_o);

  ac97_sample_fifo #(.fifo_depth(fifo_depth)) play_fifo_i (
    .clk_adc_125mhz, .adc_rstn_i, .clear_i(play_clear), .push_i(play_push),
    .din_i(play_pair), .pop_i(tick_48k_o), .dout_o(play_head), .level_o(play_level));

  ac97_sample_fifo #(.fifo_depth(fifo_depth)) rec_fifo_i (
    .clk_adc_125mhz, .adc_rstn_i, .clear_i(rec_clear), .push_i(tick_48k_o),
    .din_i(line_in_i), .pop_i(rec_pop), .dout_o(rec_head), .level_o(rec_level));

  ac97_stream_irq #(.play_irq_level(play_irq_level), .rec_irq_level(rec_irq_level)) irq_i (
    .clk_adc_125mhz, .adc_rstn_i, .tick_48k_i(tick_48k_o), .play_level_i(play_level),
    .rec_level_i(rec_level), .play_clear_i(play_clear), .rec_clear_i(rec_clear),
    .irq_play_o, .irq_rec_o, .play_underrun_o(play_underrun), .rec_overrun_o(rec_overrun));

  ac97_codec_regs codec_regs_i (
    .clk_adc_125mhz, .adc_rstn_i, .word_addr_i(codec_addr), .wdata_i(codec_wdata),
    .store_i(codec_store), .recall_i(codec_recall), .rdata_o(codec_rdata),
    .access_done_o(codec_done));

  ac97_bus_regs bus_regs_i (
    .clk_adc_125mhz, .adc_rstn_i, .sys_req_i, .sys_rdata_o, .sys_ack_o,
    .play_push_o(play_push), .play_pair_o(play_pair), .play_clear_o(play_clear),
    .rec_head_i(rec_head), .rec_pop_o(rec_pop), .rec_clear_o(rec_clear),
    .play_level_i(play_level), .rec_level_i(rec_level), .play_underrun_i(play_underrun),
    .rec_overrun_i(rec_overrun), .codec_addr_o(codec_addr), .codec_wdata_o(codec_wdata),
    .codec_store_o(codec_store), .codec_recall_o(codec_recall),
    .codec_rdata_i(codec_rdata), .codec_access_done_i(codec_done));

  //--------------------
  // line out, loads the head as the fifo pops it
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i)
      line_out_o <= '0;
    else if (tick_48k_o && !play_level.empty)
      line_out_o <= play_head;                   // holds on underrun
  end

endmodule

/* tb_ac97_top.sv */
//--------------------
// ac97 stream testbench
// strobe timing, playback, record, sticky
// flags, fifo reset and codec shadow,
// checked against a queue model of both fifos
//--------------------
`timescale 1ns/1ps

module tb_ac97_top;
  import ac97_audio_pkg::*;
  import ac97_bus_pkg::*;

  localparam int fifo_depth  = 16;
  localparam int frame_cyc   = 15625;                  // one 8 kHz frame
  localparam int watchdog_ns = 12 * frame_cyc * 8 + 50000;

  logic        clk_adc_125mhz = 1'b0;
  logic        adc_rstn_i;
  sys_req_t    sys_req_i;
  logic [31:0] sys_rdata_o;
  logic        sys_ack_o;
  stereo_t     line_in_i;
  stereo_t     line_out_o;
  logic        tick_48k_o, tick_8k_o;
  logic        irq_play_o, irq_rec_o;

  //--------------------
  // reference model state
  stereo_t     play_q[$];
  stereo_t     rec_q[$];
  stereo_t     exp_line;                               // expected line out
  logic        underrun, overrun, codec_done;
  logic [31:0] rng;
  int          cyc, last_48k, last_8k, long_cnt;

  ac97_top #(
    .fifo_depth(fifo_depth), .play_irq_level(irq_half_empty), .rec_irq_level(irq_half_full)
  ) ac97_top_i (
    .clk_adc_125mhz, .adc_rstn_i, .sys_req_i, .sys_rdata_o, .sys_ack_o, .line_in_i,
    .line_out_o, .tick_48k_o, .tick_8k_o, .irq_play_o, .irq_rec_o);

  always #4 clk_adc_125mhz = ~clk_adc_125mhz;          // 125 MHz

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // status word as the register map defines it
  function automatic logic [31:0] status_ref();
    logic [31:0] s;
    s                      = '0;
    s[stat_play_full]      = (play_q.size() == fifo_depth);
    s[stat_play_half_full] = (play_q.size() >= fifo_depth / 2);
    s[stat_rec_full]       = (rec_q.size() == fifo_depth);
    s[stat_rec_empty]      = (rec_q.size() == 0);
    s[stat_access_done]    = codec_done;
    s[stat_codec_ready]    = 1'b1;                     // start-up long over
    s[stat_play_underrun]  = underrun;
    s[stat_rec_overrun]    = overrun;
    return s;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_adc_125mhz);
      #1;                                              // drive just after the edge
    end
  endtask

  // request held one cycle, then wait for the ack
  task automatic bus_access(input logic wen, input logic ren, input logic [19:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    n = 0;
    sys_req_i = '{addr: addr, wdata: wdata, wen: wen, ren: ren};
    idle(1);
    sys_req_i = '0;
    while (!sys_ack_o && n < 8) begin
      idle(1);
      n++;
    end
    if (!sys_ack_o) stop_on_error("no sys_ack_o came back for a bus request");
    rdata = sys_rdata_o;                               // valid with the ack
  endtask

  task automatic bus_write(input logic [19:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, 1'b0, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [19:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, 1'b1, addr, '0, rdata);
  endtask

  // returns just past the edge where the fifos act on the strobe
  task automatic wait_tick();
    int n;
    n = 0;
    do begin
      idle(1);
      n++;
    end while (!tick_48k_o && n < 3000);
    if (!tick_48k_o) stop_on_error("tick_48k_o did not arrive in time");
    idle(1);
    line_in_i = next_rand();                           // next capture value
  endtask

  task automatic read_rec_pair();
    logic [31:0] lo, hi;
    stereo_t     exp;
    bus_read(reg_rec_fifo, lo);
    bus_read(reg_rec_fifo, hi);
    exp = rec_q.pop_front();
    check_val("sys_rdata_o rec left", lo, {16'h0, exp.left});
    check_val("sys_rdata_o rec right", hi, {16'h0, exp.right});
    idle(1);                                           // pop lands before next read
  endtask

  task automatic codec_write(input logic [5:0] a, input logic [15:0] d);
    bus_write(reg_codec_wdata, {16'h0, d});
    bus_write(reg_codec_addr, {24'h0, 1'b0, a, 1'b0}); // bit 7 clear, store
  endtask

  task automatic codec_read(input logic [5:0] a, output logic [15:0] d);
    logic [31:0] s, r;
    int          n;
    n = 0;
    bus_write(reg_codec_addr, {24'h0, 1'b1, a, 1'b0}); // bit 7 set, recall
    do begin
      bus_read(reg_status, s);
      n++;
    end while (!s[stat_access_done] && n < 16);
    if (!s[stat_access_done]) stop_on_error("codec read never reported access done");
    bus_read(reg_codec_rdata, r);
    d = r[15:0];
  endtask

  //--------------------
  // strobe timing, line out, irq levels and the fifo model
  always @(posedge clk_adc_125mhz) begin
    if (adc_rstn_i) begin
      cyc++;
      check_val("line_out_o", line_out_o, exp_line);
      if (tick_8k_o && !tick_48k_o) stop_on_error("tick_8k_o was high without tick_48k_o");
      if (tick_48k_o) begin
        if (last_48k == 0)
          check_val("first tick_48k_o cycle", cyc, 2606); // rises 2605 edges in, seen one later
        else if (cyc - last_48k == 2605)
          long_cnt++;
        else
          check_val("tick_48k_o interval", cyc - last_48k, 2604);
        last_48k = cyc;
        if (tick_8k_o) begin
          if (last_8k != 0) begin
            check_val("tick_8k_o interval", cyc - last_8k, frame_cyc);
            check_val("long tick_48k_o intervals per frame", long_cnt, 1);
          end
          last_8k  = cyc;
          long_cnt = 0;
        end
        check_val("irq_play_o", 32'(irq_play_o), 32'(play_q.size() < fifo_depth / 2));
        check_val("irq_rec_o", 32'(irq_rec_o), 32'(rec_q.size() >= fifo_depth / 2));
        if (play_q.size() == 0) underrun = 1'b1;       // nothing to play
        else exp_line = play_q.pop_front();
        if (rec_q.size() == fifo_depth) overrun = 1'b1; // capture dropped
        else rec_q.push_back(line_in_i);
      end
    end
  end

  initial begin
    #(watchdog_ns);
    stop_on_error("watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] s;
    logic [15:0] d;
    logic [5:0]  waddr [5];
    logic [15:0] wval [5];
    stereo_t     pair;
    rng        = 32'h9c7bd589;
    sys_req_i  = '0;
    line_in_i  = next_rand();
    adc_rstn_i = 1'b0;
    exp_line   = '0;
    underrun   = 1'b0;
    overrun    = 1'b0;
    codec_done = 1'b0;
    waddr      = '{6'h02, 6'h0a, 6'h13, 6'h2c, 6'h3f};
    repeat (5) @(posedge clk_adc_125mhz);
    #1 adc_rstn_i = 1'b1;

    //--------------------
    // playback, 12 pairs from an empty fifo
    wait_tick();
    bus_write(reg_fifo_reset, 32'h3);
    play_q.delete();
    rec_q.delete();
    underrun = 1'b0;
    overrun  = 1'b0;
    for (int i = 0; i < 12; i++) begin
      pair = next_rand();
      bus_write(reg_play_fifo, {16'h0, pair.left});
      bus_write(reg_play_fifo, {16'h0, pair.right});
      play_q.push_back(pair);
    end
    idle(2);                                           // last push settles
    bus_read(reg_status, s);
    check_val("status play_half_full", 32'(s[stat_play_half_full]), 1);
    check_val("sys_rdata_o status", s, status_ref());

    //--------------------
    // record
    while (rec_q.size() < fifo_depth / 2) wait_tick();
    idle(2);                                           // irq lags the level
    check_val("irq_rec_o", 32'(irq_rec_o), 1);
    while (rec_q.size() > 0) read_rec_pair();

    //--------------------
    // sticky flags and fifo reset
    while (play_q.size() > 0) wait_tick();
    wait_tick();
    bus_read(reg_status, s);
    check_val("status play_underrun", 32'(s[stat_play_underrun]), 1);
    while (rec_q.size() < fifo_depth) wait_tick();
    wait_tick();
    bus_read(reg_status, s);
    check_val("status rec_overrun", 32'(s[stat_rec_overrun]), 1);
    bus_write(reg_fifo_reset, 32'h3);
    play_q.delete();
    rec_q.delete();
    underrun = 1'b0;
    overrun  = 1'b0;
    idle(2);
    bus_read(reg_status, s);
    check_val("sys_rdata_o status after fifo reset", s, status_ref());

    //--------------------
    // codec shadow
    foreach (waddr[i]) begin
      wval[i] = 16'(next_rand());
      if (waddr[i] == 6'h13) wval[i] = wval[i] & 16'hfff0; // ready bits start clear
      codec_write(waddr[i], wval[i]);
    end
    foreach (waddr[i]) begin
      codec_read(waddr[i], d);
      if (waddr[i] == 6'h13) begin
        check_val("codec word 0x13 ready bits", 32'(d[3:0]), 32'hf);
        check_val("codec rdata", 32'(d), 32'(wval[i] | 16'h000f));
      end else begin
        check_val("codec rdata", 32'(d), 32'(wval[i]));
      end
    end
    codec_done = 1'b1;
    wait_tick();
    bus_read(reg_status, s);
    check_val("sys_rdata_o final status", s, status_ref());
    $display("Everything OK");
    $finish;
  end

endmodule

/* vlog.f */
ac97_audio_pkg.sv
ac97_bus_pkg.sv
ac97_rate_gen.sv
ac97_sample_fifo.sv
ac97_stream_irq.sv
ac97_codec_regs.sv
ac97_bus_regs.sv
ac97_top.sv
tb_ac97_top.sv

/* Makefile */
# Verilator build and run of the ac97 stream testbench

SIM := obj_dir/Vtb_ac97_top

$(SIM): vlog.f $(shell cat vlog.f)
	verilator --binary --timing --assert --top-module tb_ac97_top -f vlog.f

.PHONY: run check clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q '^Everything OK$$' sim.log

check:
	@grep -q '^Everything OK$$' sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log
